// ==== filelist.f ====
design/ldpc_msg_pkg.sv
design/ib_table_pkg.sv
design/vnu_row_if.sv
design/c2v_latch_bank.sv
design/ib_vn_table.sv
design/vnu_row_datapath.sv
design/decision_tracker.sv
design/row_vnu_wrapper.sv
sim/tb_clock_gen.sv
sim/row_vnu_tb.sv

// ==== Makefile ====
TOP = row_vnu_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir
	-./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/row_vnu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module row_vnu_tb import ldpc_msg_pkg::*; import ib_table_pkg::*; ();

	// reset, table load, tests 2 to 6 with drains, tail
	localparam int STIM_CYCLES = 5 + 32 + 13 + 21 + 9 + 10 + 13 + 4;
	localparam int TIMEOUT     = 4 * STIM_CYCLES;

	typedef struct packed {
		logic [ROW_LANES*MSG_W-1:0] v2c;
		decision_t                  hard;
		frame_t                     frame;
		logic                       stable;
		logic [31:0]                cycle; // counter value when the result shows
	} expect_t;

	wire       read_clk;
	wire       reset;
	logic      c2v_latch_en;
	logic      c2v_parallel_load;
	logic      ib_ram_we;
	frame_t    read_addr_offset;
	ib_page_t  page_addr_ram;
	ib_word_t  ram_write_data;
	msg_t      ch_msg  [ROW_LANES];
	msg_t      c2v_in0 [ROW_LANES];
	msg_t      c2v_in1 [ROW_LANES];
	msg_t      c2v_in2 [ROW_LANES];
	msg_t      v2c_out [ROW_LANES];
	decision_t hard_decision;
	logic      result_valid;
	frame_t    result_frame;
	logic      decision_stable;

	// model state
	msg_t        stim_ch [ROW_LANES];
	msg_t        stim_c0 [ROW_LANES];
	msg_t        stim_c1 [ROW_LANES];
	msg_t        stim_c2 [ROW_LANES];
	msg_t        shadow  [IB_ENTRIES];      // mirror of the IB table
	decision_t   ref_word [MULTI_FRAME_NUM];
	logic        ref_seen [MULTI_FRAME_NUM];
	expect_t     exp_q [$];
	expect_t     got;
	int unsigned cycle_count = 0;
	logic [31:0] lcg_state   = 32'hf863;

	tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(5)) clock_gen_i (
		.clk   (read_clk),
		.reset (reset)
	);

	row_vnu_wrapper row_vnu_wrapper_i (
		.read_clk          (read_clk),
		.reset             (reset),
		.c2v_latch_en      (c2v_latch_en),
		.c2v_parallel_load (c2v_parallel_load),
		.read_addr_offset  (read_addr_offset),
		.ch_msg            (ch_msg),
		.c2v_in0           (c2v_in0),
		.c2v_in1           (c2v_in1),
		.c2v_in2           (c2v_in2),
		.ib_ram_we         (ib_ram_we),
		.page_addr_ram     (page_addr_ram),
		.ram_write_data    (ram_write_data),
		.v2c_out           (v2c_out),
		.hard_decision     (hard_decision),
		.result_valid      (result_valid),
		.result_frame      (result_frame),
		.decision_stable   (decision_stable)
	);

	//////////////////////////////
	// model helpers
	//////////////////////////////
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic msg_t random_msg();
		lcg_state = lcg_next(lcg_state);
		return msg_t'(lcg_state[27:24]); // upper bits, better spread
	endfunction

	// v2c from the shadow table, sign of the four-term sum, frame history
	function automatic expect_t reference_result(input frame_t f);
		expect_t r;
		int      ext;
		int      full;
		r = '0;
		for (int i = 0; i < ROW_LANES; i++) begin
			ext  = int'(stim_ch[i]) + int'(stim_c1[i]) + int'(stim_c2[i]); // skips edge 0
			full = ext + int'(stim_c0[i]);
			r.v2c[i*MSG_W +: MSG_W] = shadow[ext + IB_OFFSET];
			r.hard[i] = (full < 0);
		end
		r.frame  = f;
		r.stable = ref_seen[f] && (ref_word[f] == r.hard);
		return r;
	endfunction

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
				$time, what, actual, expected);
			$display("Test failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic set_lane(input int lane, input msg_t value);
		stim_ch[lane] = value;
		stim_c0[lane] = value;
		stim_c1[lane] = value;
		stim_c2[lane] = value;
	endtask

	task automatic fill_random();
		for (int i = 0; i < ROW_LANES; i++) begin
			stim_ch[i] = random_msg();
			stim_c0[i] = random_msg();
			stim_c1[i] = random_msg();
			stim_c2[i] = random_msg();
		end
	endtask

	task automatic set_pattern(input decision_t bits);
		for (int i = 0; i < ROW_LANES; i++)
			set_lane(i, bits[i] ? msg_t'(-1) : msg_t'(1)); // sum -4 or +4
	endtask

	//////////////////////////////
	// drivers, 1 ns after the edge
	//////////////////////////////
	task automatic drive_controls(input logic latch, input logic pload, input logic we);
		@(posedge read_clk);
		#1;
		c2v_latch_en      = latch;
		c2v_parallel_load = pload;
		ib_ram_we         = we;
	endtask

	task automatic drive_strobe(input frame_t f);
		expect_t r;
		drive_controls(1'b1, 1'b0, 1'b0);
		read_addr_offset = f;
		ch_msg  = stim_ch;
		c2v_in0 = stim_c0;
		c2v_in1 = stim_c1;
		c2v_in2 = stim_c2;
		r = reference_result(f);
		r.cycle = cycle_count + 1 + VN_PIPELINE_DEPTH; // sampled at the next edge
		ref_seen[f] = 1'b1;
		ref_word[f] = r.hard;
		exp_q.push_back(r);
	endtask

	// only called with nothing in flight
	task automatic write_page(input ib_page_t page, input ib_word_t data);
		drive_controls(1'b0, 1'b0, 1'b1);
		page_addr_ram  = page;
		ram_write_data = data;
		shadow[{page, 1'b0}] = msg_t'(data[MSG_W-1:0]);
		shadow[{page, 1'b1}] = msg_t'(data[2*MSG_W-1:MSG_W]);
	endtask

	task automatic drain();
		drive_controls(1'b0, 1'b0, 1'b0);
		while (exp_q.size() != 0)
			@(posedge read_clk);
	endtask

	//////////////////////////////
	// compare and watchdog
	//////////////////////////////
	always @(negedge read_clk) begin // outputs settled since the rising edge
		if (reset === 1'b0) begin
			if (result_valid) begin
				if (exp_q.size() == 0) begin
					$display("result_valid at %0t ns with no result expected", $time);
					$display("Test failed");
					$fatal(1, "unexpected result");
				end else begin
					got = exp_q.pop_front();
					check_value(cycle_count, got.cycle, "result latency");
					check_value(result_frame, got.frame, "result_frame");
					check_value(hard_decision, got.hard, "hard_decision");
					check_value(decision_stable, got.stable, "decision_stable");
					for (int i = 0; i < ROW_LANES; i++)
						check_value($unsigned(v2c_out[i]), got.v2c[i*MSG_W +: MSG_W],
							$sformatf("v2c lane %0d", i));
				end
			end else begin
				check_value(decision_stable, 1'b0, "decision_stable without a result");
			end
		end
	end

	always @(posedge read_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT) begin
			$display("timeout, run still going after %0d cycles", TIMEOUT);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////
	initial begin
		ib_page_t  page;
		decision_t pat_a;
		decision_t pat_b;
		c2v_latch_en      = 1'b0;
		c2v_parallel_load = 1'b0;
		ib_ram_we         = 1'b0;
		read_addr_offset  = '0;
		page_addr_ram     = '0;
		ram_write_data    = '0;
		for (int i = 0; i < ROW_LANES; i++) begin
			ch_msg[i]  = '0;
			c2v_in0[i] = '0;
			c2v_in1[i] = '0;
			c2v_in2[i] = '0;
		end
		for (int f = 0; f < MULTI_FRAME_NUM; f++) begin
			ref_seen[f] = 1'b0;
			ref_word[f] = '0;
		end
		wait (reset === 1'b1);
		wait (reset === 1'b0);
		@(negedge read_clk);
		check_value(result_valid, 1'b0, "result_valid after reset");
		check_value(decision_stable, 1'b0, "decision_stable after reset");

		// full table load, then extremes on lanes 0 and 1
		for (int p = 0; p < IB_ENTRIES / IB_BANK_NUM; p++)
			write_page(ib_page_t'(p), {random_msg(), random_msg()});
		for (int k = 0; k < 4; k++) begin
			fill_random();
			set_lane(0, msg_t'(7));  // ext +21, entry 53
			set_lane(1, msg_t'(-8)); // ext -24, entry 8
			drive_strobe(frame_t'(k));
			drive_controls(1'b0, 1'b0, 1'b0);
		end
		drain();

		// back to back, three in flight
		for (int k = 0; k < 16; k++) begin
			fill_random();
			drive_strobe(frame_t'(k));
		end
		drain();

		// parallel load alone, then with latch_en
		fill_random();
		drive_strobe(1'b0);
		drive_controls(1'b0, 1'b1, 1'b0);
		drive_controls(1'b1, 1'b1, 1'b0); // load wins, no result
		fill_random();
		drive_strobe(1'b1);
		drain();

		// per-frame stability, words unlike the history
		pat_a = ~ref_word[0];
		pat_b = ~ref_word[1];
		for (int k = 0; k < 2; k++) begin
			set_pattern(pat_a);
			drive_strobe(1'b0);
			set_pattern(pat_b);
			drive_strobe(1'b1);
		end
		pat_a[3] = ~pat_a[3]; // one lane flips
		set_pattern(pat_a);
		drive_strobe(1'b0);
		drain();

		// rewrite the page behind lane 0, same inputs again
		fill_random();
		drive_strobe(1'b0);
		drain();
		page = ib_page_t'((int'(stim_ch[0]) + int'(stim_c1[0]) + int'(stim_c2[0])
			+ IB_OFFSET) / 2);
		write_page(page, ~{shadow[{page, 1'b1}], shadow[{page, 1'b0}]});
		drive_strobe(1'b0);
		drain();

		repeat (VN_PIPELINE_DEPTH + 1) @(posedge read_clk); // catch stray results
		if (exp_q.size() != 0) begin
			$display("%0d expected results never arrived", exp_q.size());
			$display("Test failed");
			$fatal(1, "results missing");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0; // released with the other inputs
	end

endmodule

`default_nettype wire

// ==== design/row_vnu_wrapper.sv ====
`timescale 1ns/1ns
`default_nettype none

module row_vnu_wrapper import ldpc_msg_pkg::*; import ib_table_pkg::*; (
	input  wire        read_clk,
	input  wire        reset,
	input  wire        c2v_latch_en,
	input  wire        c2v_parallel_load,
	input  frame_t     read_addr_offset,
	input  msg_t       ch_msg  [ROW_LANES],
	input  msg_t       c2v_in0 [ROW_LANES],
	input  msg_t       c2v_in1 [ROW_LANES],
	input  msg_t       c2v_in2 [ROW_LANES],
	// IB table page refresh
	input  wire        ib_ram_we,
	input  ib_page_t   page_addr_ram,
	input  ib_word_t   ram_write_data,
	// results, three cycles after the latch strobe
	output msg_t       v2c_out [ROW_LANES],
	output decision_t  hard_decision,
	output logic       result_valid,
	output frame_t     result_frame,
	output logic       decision_stable
);

	vnu_in_if  in_bus ();
	vnu_out_if out_bus ();

	c2v_latch_bank u_latch (
		.read_clk          (read_clk),
		.reset             (reset),
		.c2v_latch_en      (c2v_latch_en),
		.c2v_parallel_load (c2v_parallel_load),
		.read_addr_offset  (read_addr_offset),
		.ch_msg            (ch_msg),
		.c2v_in0           (c2v_in0),
		.c2v_in1           (c2v_in1),
		.c2v_in2           (c2v_in2),
		.vin               (in_bus.source)
	);

	vnu_row_datapath u_datapath (
		.read_clk       (read_clk),
		.reset          (reset),
		.ib_ram_we      (ib_ram_we),
		.page_addr_ram  (page_addr_ram),
		.ram_write_data (ram_write_data),
		.vin            (in_bus.sink),
		.vout           (out_bus.source)
	);

	decision_tracker u_tracker (
		.read_clk        (read_clk),
		.reset           (reset),
		.vout            (out_bus.sink),
		.v2c_out         (v2c_out),
		.hard_decision   (hard_decision),
		.result_valid    (result_valid),
		.result_frame    (result_frame),
		.decision_stable (decision_stable)
	);

endmodule

`default_nettype wire

// ==== design/decision_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

module decision_tracker import ldpc_msg_pkg::*; (
	input  wire        read_clk,
	input  wire        reset,
	vnu_out_if.sink    vout,
	output msg_t       v2c_out [ROW_LANES],
	output decision_t  hard_decision,
	output logic       result_valid,
	output frame_t     result_frame,
	output logic       decision_stable // same word as last time for this frame
);

	decision_t last_word [MULTI_FRAME_NUM]; // previous word per frame
	logic      seen      [MULTI_FRAME_NUM]; // frame has produced a word

	////////////////////////////////
	// result registers
	////////////////////////////////
	always_ff @(posedge read_clk) begin
		v2c_out       <= vout.v2c;
		hard_decision <= vout.hard;
		result_frame  <= vout.out_frame;
	end

	always_ff @(posedge read_clk) begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= vout.out_valid;
	end

	////////////////////////////////
	// per-frame history
	////////////////////////////////
	always_ff @(posedge read_clk) begin
		if (reset) begin
			decision_stable <= 1'b0;
			for (int f = 0; f < MULTI_FRAME_NUM; f++)
				seen[f] <= 1'b0; // both stored words invalid
		end else begin
			decision_stable <= vout.out_valid && seen[vout.out_frame]
				&& (last_word[vout.out_frame] == vout.hard);
			if (vout.out_valid)
				seen[vout.out_frame] <= 1'b1;
		end
	end

	// stored word always replaced, compare uses the old one
	always_ff @(posedge read_clk) begin
		if (vout.out_valid)
			last_word[vout.out_frame] <= vout.hard;
	end

endmodule

`default_nettype wire

// ==== design/vnu_row_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module vnu_row_datapath import ldpc_msg_pkg::*; import ib_table_pkg::*; (
	input  wire        read_clk,
	input  wire        reset,
	input  wire        ib_ram_we,
	input  ib_page_t   page_addr_ram,
	input  ib_word_t   ram_write_data,
	vnu_in_if.sink     vin,
	vnu_out_if.source  vout
);

	sum_t      ext_sum  [ROW_LANES]; // ch + c2v1 + c2v2
	sum_t      full_sum [ROW_LANES]; // ext + c2v0
	sum_t      s1_ext   [ROW_LANES];
	sum_t      s1_full  [ROW_LANES];
	logic      s1_valid;
	frame_t    s1_frame;
	ib_index_t lut_index [ROW_LANES];

	////////////////////////////////
	// stage 1 sums
	////////////////////////////////
	always_comb begin
		for (int i = 0; i < ROW_LANES; i++) begin
			// sign-extend each message before adding
			ext_sum[i]  = sum_t'(vin.ch[i]) + sum_t'(vin.c2v1[i]) + sum_t'(vin.c2v2[i]);
			full_sum[i] = ext_sum[i] + sum_t'(vin.c2v0[i]);
		end
	end

	always_ff @(posedge read_clk) begin
		s1_ext   <= ext_sum;
		s1_full  <= full_sum;
		s1_frame <= vin.in_frame;
	end

	always_ff @(posedge read_clk) begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= vin.in_valid;
	end

	////////////////////////////////
	// stage 2 IB lookup
	////////////////////////////////
	always_comb begin
		for (int i = 0; i < ROW_LANES; i++)
			lut_index[i] = ib_index_t'(s1_ext[i]) + ib_index_t'(IB_OFFSET); // -32 -> entry 0
	end

	ib_vn_table u_table (
		.read_clk       (read_clk),
		.ib_ram_we      (ib_ram_we),
		.page_addr_ram  (page_addr_ram),
		.ram_write_data (ram_write_data),
		.rd_index       (lut_index),
		.rd_data        (vout.v2c)      // registered so it lands with stage 2
	);

	// sign bits and tag delayed to meet the table output
	always_ff @(posedge read_clk) begin
		for (int i = 0; i < ROW_LANES; i++)
			vout.hard[i] <= s1_full[i][SUM_W-1];
		vout.out_frame <= s1_frame;
	end

	always_ff @(posedge read_clk) begin
		if (reset)
			vout.out_valid <= 1'b0;
		else
			vout.out_valid <= s1_valid;
	end

	// a lookup of an entry never written comes back unknown
	for (genvar i = 0; i < ROW_LANES; i++) begin : g_lane_chk
		a_v2c_known: assert property (@(posedge read_clk) disable iff (reset)
			vout.out_valid |-> !$isunknown(vout.v2c[i]))
			else $error("v2c lane %0d is unknown with out_valid", i);
	end

endmodule

`default_nettype wire

// ==== design/ib_vn_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module ib_vn_table import ldpc_msg_pkg::*; import ib_table_pkg::*; (
	input  wire       read_clk,
	input  wire       ib_ram_we,        // page write strobe
	input  ib_page_t  page_addr_ram,
	input  ib_word_t  ram_write_data,   // two entries per page
	input  ib_index_t rd_index [ROW_LANES],
	output msg_t      rd_data  [ROW_LANES]
);

	msg_t mem [IB_ENTRIES]; // shared by all lanes

	////////////////////////////////
	// page write
	////////////////////////////////
	always_ff @(posedge read_clk) begin
		if (ib_ram_we) begin
			for (int b = 0; b < IB_BANK_NUM; b++) begin
				// bank b lands on entry page*2 + b
				mem[{page_addr_ram, IB_BANK_W'(b)}] <= ram_write_data[b*MSG_W +: MSG_W];
			end
		end
	end

	////////////////////////////////
	// ten registered read ports
	////////////////////////////////
	// same-edge write is not seen here, old entry comes out
	always_ff @(posedge read_clk) begin
		for (int i = 0; i < ROW_LANES; i++)
			rd_data[i] <= mem[rd_index[i]];
	end

	// an X strobe would corrupt a whole page silently
	a_we_known: assert property (@(posedge read_clk)
		!$isunknown(ib_ram_we))
		else $error("ib_ram_we is unknown");

endmodule

`default_nettype wire

// ==== design/c2v_latch_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module c2v_latch_bank import ldpc_msg_pkg::*; (
	input  wire        read_clk,
	input  wire        reset,
	input  wire        c2v_latch_en,
	input  wire        c2v_parallel_load, // clears c2v and wins over latch_en
	input  frame_t     read_addr_offset,  // frame of the incoming lanes
	input  msg_t       ch_msg  [ROW_LANES],
	input  msg_t       c2v_in0 [ROW_LANES],
	input  msg_t       c2v_in1 [ROW_LANES],
	input  msg_t       c2v_in2 [ROW_LANES],
	vnu_in_if.source   vin
);

	// message latches hold payload only
	always_ff @(posedge read_clk) begin
		if (c2v_parallel_load) begin
			for (int i = 0; i < ROW_LANES; i++) begin
				vin.c2v0[i] <= '0;
				vin.c2v1[i] <= '0;
				vin.c2v2[i] <= '0;
			end
		end else if (c2v_latch_en) begin
			for (int i = 0; i < ROW_LANES; i++) begin
				vin.ch[i]   <= ch_msg[i];
				vin.c2v0[i] <= c2v_in0[i];
				vin.c2v1[i] <= c2v_in1[i];
				vin.c2v2[i] <= c2v_in2[i];
			end
			vin.in_frame <= read_addr_offset; // tag travels with the lanes
		end
	end

	// no valid on a parallel load
	always_ff @(posedge read_clk) begin
		if (reset)
			vin.in_valid <= 1'b0;
		else
			vin.in_valid <= c2v_latch_en && !c2v_parallel_load;
	end

	// an X strobe would leave in_valid and the latches unknown
	a_strobes_known: assert property (@(posedge read_clk) disable iff (reset)
		!$isunknown({c2v_latch_en, c2v_parallel_load}))
		else $error("latch strobe is unknown");

endmodule

`default_nettype wire

// ==== design/vnu_row_if.sv ====
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////
// latch bank -> datapath
////////////////////////////////
interface vnu_in_if import ldpc_msg_pkg::*; ();
	msg_t   ch   [ROW_LANES]; // channel message
	msg_t   c2v0 [ROW_LANES]; // edge 0, only in full sum
	msg_t   c2v1 [ROW_LANES];
	msg_t   c2v2 [ROW_LANES];
	logic   in_valid;         // one-cycle pulse
	frame_t in_frame;

	modport source (
		output ch, c2v0, c2v1, c2v2, in_valid, in_frame
	);
	modport sink (
		input ch, c2v0, c2v1, c2v2, in_valid, in_frame
	);
endinterface

////////////////////////////////
// datapath -> decision tracker
////////////////////////////////
interface vnu_out_if import ldpc_msg_pkg::*; ();
	msg_t      v2c [ROW_LANES]; // edge-0 v2c from IB table
	decision_t hard;
	logic      out_valid;       // pulse
	frame_t    out_frame;

	modport source (
		output v2c, hard, out_valid, out_frame
	);
	modport sink (
		input v2c, hard, out_valid, out_frame
	);
endinterface

`default_nettype wire

// ==== design/ib_table_pkg.sv ====
`default_nettype none

package ib_table_pkg;
	import ldpc_msg_pkg::*;

	localparam int IB_ENTRIES  = 64; // one entry per sum value
	localparam int IB_BANK_NUM = 2;  // entries per page write
	localparam int IB_BANK_W   = $clog2(IB_BANK_NUM);
	localparam int IB_INDEX_W  = $clog2(IB_ENTRIES);
	localparam int IB_PAGE_W   = IB_INDEX_W - IB_BANK_W;
	localparam int IB_WORD_W   = IB_BANK_NUM * MSG_W; // one msg_t per bank

	// offset binary, index = sum + 32
	localparam int IB_OFFSET   = IB_ENTRIES / 2;

	typedef logic [IB_PAGE_W-1:0]  ib_page_t;
	typedef logic [IB_WORD_W-1:0]  ib_word_t;  // [3:0] even entry, [7:4] odd
	typedef logic [IB_INDEX_W-1:0] ib_index_t;

endpackage

`default_nettype wire

// ==== design/ldpc_msg_pkg.sv ====
`default_nettype none

package ldpc_msg_pkg;

	////////////////////////////////
	// row geometry
	////////////////////////////////
	localparam int ROW_LANES         = 10; // variable-node lanes in one row
	localparam int VN_DEGREE         = 3;  // c2v edges per lane
	localparam int MULTI_FRAME_NUM   = 2;  // interleaved frames
	localparam int VN_PIPELINE_DEPTH = 3; // strobe to result_valid, in cycles

	////////////////////////////////
	// message widths
	////////////////////////////////
	localparam int MSG_W   = 4;
	// room for ch plus all c2v edges
	localparam int SUM_W   = MSG_W + $clog2(VN_DEGREE + 1);
	localparam int FRAME_W = $clog2(MULTI_FRAME_NUM);

	typedef logic signed [MSG_W-1:0]   msg_t;      // c2v, v2c, channel
	typedef logic signed [SUM_W-1:0]   sum_t;      // extrinsic / full sums
	typedef logic [FRAME_W-1:0]        frame_t;    // frame offset tag
	typedef logic [ROW_LANES-1:0]      decision_t; // 1 = negative sum

endpackage

`default_nettype wire
